//--- logic/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Data path width in bits
`define LSU_XLEN 32

// Memory depth in words
`define LSU_MEM_WORDS 4096

// Word index taken from byte address bits [13:2]
`define LSU_IDX_W 12

// Reorder buffer tag width
`define LSU_TAG_W 6

`endif

//--- logic/lsu_pkg.sv
package lsu_pkg;

    // Access width and sign in RISC-V funct3 encoding
    // Stores reuse the first three values as SB, SH and SW
    typedef enum logic [2:0] {
        OP_B  = 3'b000,  // LB or SB
        OP_H  = 3'b001,  // LH or SH
        OP_W  = 3'b010,  // LW or SW
        OP_BU = 3'b100,  // LBU for loads only
        OP_HU = 3'b101   // LHU for loads only
    } mem_op_t;

endpackage

//--- logic/data_memory.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module data_memory (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`LSU_IDX_W-1:0]  rd_a_idx,   // Speculative load port
    input  logic [`LSU_IDX_W-1:0]  rd_b_idx,   // Commit verification port
    input  logic                   wr_en,
    input  logic [`LSU_IDX_W-1:0]  wr_idx,
    input  logic [3:0]             wr_byte_en,
    input  logic [`LSU_XLEN-1:0]   wr_word,    // Already placed in its lanes
    output logic [`LSU_XLEN-1:0]   rd_a_word,
    output logic [`LSU_XLEN-1:0]   rd_b_word
);

    logic [`LSU_XLEN-1:0] mem [0:`LSU_MEM_WORDS-1];

    // Reset fills every word with its index plus 3 in a single cycle.
    // Outside reset only the enabled byte lanes of the target word change.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
                mem[i] <= `LSU_XLEN'(i + 3);  // Known startup pattern
            end
        end else if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_byte_en[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    // Reads see the contents before the write at the coming edge
    assign rd_a_word = mem[rd_a_idx];
    assign rd_b_word = mem[rd_b_idx];

endmodule

//--- logic/load_extract.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_extract (
    input  logic [`LSU_XLEN-1:0] word,
    input  logic [1:0]           byte_off,
    input  lsu_pkg::mem_op_t     op,
    output logic [`LSU_XLEN-1:0] data,
    output logic                 misaligned
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    assign byte_lane = word[{byte_off, 3'b000} +: 8];
    assign half_lane = word[{byte_off[1], 4'b0000} +: 16];  // Upper or lower half

    always_comb begin
        data       = '0;  // Unsupported opcode reads as zero
        misaligned = 1'b0;
        case (op)
            lsu_pkg::OP_B:  data = {{24{byte_lane[7]}}, byte_lane};
            lsu_pkg::OP_BU: data = {24'b0, byte_lane};
            lsu_pkg::OP_H: begin
                data       = {{16{half_lane[15]}}, half_lane};
                misaligned = byte_off[0];   // Odd offset
            end
            lsu_pkg::OP_HU: begin
                data       = {16'b0, half_lane};
                misaligned = byte_off[0];
            end
            lsu_pkg::OP_W: begin
                data       = word;
                misaligned = |byte_off;     // Any nonzero offset
            end
            default: data = '0;
        endcase
    end

endmodule

//--- logic/load_issue.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_issue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ld_valid,
    input  logic [`LSU_XLEN-1:0]   ld_addr,
    input  lsu_pkg::mem_op_t       ld_op,
    input  logic [`LSU_TAG_W-1:0]  ld_tag,
    input  logic [`LSU_XLEN-1:0]   rd_word,
    output logic [`LSU_IDX_W-1:0]  rd_idx,
    output logic                   ld_done,
    output logic [`LSU_XLEN-1:0]   ld_data,
    output logic [`LSU_TAG_W-1:0]  ld_tag_out,
    output logic                   ld_fault
);

    logic [`LSU_XLEN-1:0] ext_data;
    logic                 misaligned;

    assign rd_idx = ld_addr[`LSU_IDX_W+1:2];  // Upper address bits wrap

    load_extract u_extract (
        .word       (rd_word),
        .byte_off   (ld_addr[1:0]),
        .op         (ld_op),
        .data       (ext_data),
        .misaligned (misaligned)
    );

    // Control flags
    always_ff @(posedge clk) begin
        if (reset) begin
            ld_done  <= 1'b0;
            ld_fault <= 1'b0;
        end else begin
            ld_done  <= ld_valid;
            ld_fault <= ld_valid & misaligned;
        end
    end

    // Result and tag of the accepted load
    always_ff @(posedge clk) begin
        if (ld_valid) begin
            ld_data    <= misaligned ? '0 : ext_data;  // Faulting load returns zero
            ld_tag_out <= ld_tag;
        end
    end

endmodule

//--- logic/commit_check.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module commit_check (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cm_valid,
    input  logic                   cm_is_store,
    input  logic [`LSU_XLEN-1:0]   cm_addr,
    input  lsu_pkg::mem_op_t       cm_op,
    input  logic [`LSU_XLEN-1:0]   cm_value,   // Store data or speculative load value
    input  logic [`LSU_XLEN-1:0]   rd_word,
    output logic [`LSU_IDX_W-1:0]  rd_idx,
    output logic                   wr_en,
    output logic [`LSU_IDX_W-1:0]  wr_idx,
    output logic [3:0]             wr_byte_en,
    output logic [`LSU_XLEN-1:0]   wr_word,
    output logic                   cm_done,
    output logic                   cm_violation,
    output logic                   cm_fault
);

    logic [`LSU_IDX_W-1:0] word_idx;
    logic [1:0]            byte_off;
    logic [`LSU_XLEN-1:0]  mem_value;
    logic                  misaligned;
    logic [3:0]            lane_en;
    logic                  mismatch;

    assign word_idx = cm_addr[`LSU_IDX_W+1:2];
    assign byte_off = cm_addr[1:0];
    assign rd_idx   = word_idx;
    assign wr_idx   = word_idx;

    // Same width and alignment rules as the speculative path
    load_extract u_extract (
        .word       (rd_word),
        .byte_off   (byte_off),
        .op         (cm_op),
        .data       (mem_value),
        .misaligned (misaligned)
    );

    // Store lane enables by width and byte offset
    always_comb begin
        case (cm_op)
            lsu_pkg::OP_B: lane_en = 4'b0001 << byte_off;
            lsu_pkg::OP_H: lane_en = 4'b0011 << byte_off;
            lsu_pkg::OP_W: lane_en = 4'b1111;
            default:       lane_en = 4'b0000;  // Unsupported store writes nothing
        endcase
    end

    assign wr_byte_en = lane_en;
    assign wr_word    = cm_value << {byte_off, 3'b000};  // Move data into its lanes
    assign wr_en      = cm_valid & cm_is_store & ~misaligned & (|lane_en);

    // Memory is read before the store at this edge lands
    assign mismatch = ~cm_is_store & ~misaligned & (mem_value != cm_value);

    always_ff @(posedge clk) begin
        if (reset) begin
            cm_done      <= 1'b0;
            cm_violation <= 1'b0;
            cm_fault     <= 1'b0;
        end else begin
            cm_done      <= cm_valid;
            cm_violation <= cm_valid & mismatch;    // Ordering violation makes the core flush
            cm_fault     <= cm_valid & misaligned;
        end
    end

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_subsystem (
    input  logic                   clk,
    input  logic                   reset,
    // Speculative load port
    input  logic                   ld_valid,
    input  logic [`LSU_XLEN-1:0]   ld_addr,
    input  lsu_pkg::mem_op_t       ld_op,
    input  logic [`LSU_TAG_W-1:0]  ld_tag,
    output logic                   ld_done,
    output logic [`LSU_XLEN-1:0]   ld_data,
    output logic [`LSU_TAG_W-1:0]  ld_tag_out,
    output logic                   ld_fault,
    // Commit port from the reorder buffer
    input  logic                   cm_valid,
    input  logic                   cm_is_store,
    input  logic [`LSU_XLEN-1:0]   cm_addr,
    input  lsu_pkg::mem_op_t       cm_op,
    input  logic [`LSU_XLEN-1:0]   cm_value,
    output logic                   cm_done,
    output logic                   cm_violation,
    output logic                   cm_fault
);

    logic [`LSU_IDX_W-1:0] rd_a_idx;
    logic [`LSU_IDX_W-1:0] rd_b_idx;
    logic [`LSU_XLEN-1:0]  rd_a_word;
    logic [`LSU_XLEN-1:0]  rd_b_word;
    logic                  wr_en;
    logic [`LSU_IDX_W-1:0] wr_idx;
    logic [3:0]            wr_byte_en;
    logic [`LSU_XLEN-1:0]  wr_word;

    data_memory u_mem (
        .clk        (clk),
        .reset      (reset),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_byte_en (wr_byte_en),
        .wr_word    (wr_word),
        .rd_a_word  (rd_a_word),
        .rd_b_word  (rd_b_word)
    );

    load_issue u_load (
        .clk        (clk),
        .reset      (reset),
        .ld_valid   (ld_valid),
        .ld_addr    (ld_addr),
        .ld_op      (ld_op),
        .ld_tag     (ld_tag),
        .rd_word    (rd_a_word),
        .rd_idx     (rd_a_idx),
        .ld_done    (ld_done),
        .ld_data    (ld_data),
        .ld_tag_out (ld_tag_out),
        .ld_fault   (ld_fault)
    );

    commit_check u_commit (
        .clk          (clk),
        .reset        (reset),
        .cm_valid     (cm_valid),
        .cm_is_store  (cm_is_store),
        .cm_addr      (cm_addr),
        .cm_op        (cm_op),
        .cm_value     (cm_value),
        .rd_word      (rd_b_word),
        .rd_idx       (rd_b_idx),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_byte_en   (wr_byte_en),
        .wr_word      (wr_word),
        .cm_done      (cm_done),
        .cm_violation (cm_violation),
        .cm_fault     (cm_fault)
    );

endmodule

//--- testbench/mem_subsystem_asserts.sv
`timescale 1ns/1ps

module mem_subsystem_asserts (
    input logic clk,
    input logic reset,
    input logic ld_valid,
    input logic ld_done,
    input logic cm_valid,
    input logic cm_done,
    input logic cm_violation,
    input logic cm_fault
);

    int failures = 0;  // Failed timing checks so far

    // Each port answers exactly one cycle after acceptance
    ld_latency: assert property (@(posedge clk) disable iff (reset) ld_valid |=> ld_done)
        else begin
            $error("ld_done did not follow ld_valid");
            failures++;
        end

    ld_no_extra: assert property (@(posedge clk) disable iff (reset) !ld_valid |=> !ld_done)
        else begin
            $error("ld_done high without a load");
            failures++;
        end

    cm_latency: assert property (@(posedge clk) disable iff (reset) cm_valid |=> cm_done)
        else begin
            $error("cm_done did not follow cm_valid");
            failures++;
        end

    cm_no_extra: assert property (@(posedge clk) disable iff (reset) !cm_valid |=> !cm_done)
        else begin
            $error("cm_done high without a commit");
            failures++;
        end

    cm_flags_need_done: assert property (@(posedge clk) disable iff (reset)
                                         (cm_violation || cm_fault) |-> cm_done)
        else begin
            $error("cm_violation or cm_fault raised without cm_done");
            failures++;
        end

    reset_clears: assert property (@(posedge clk)
                                   reset |=> !ld_done && !cm_done && !cm_violation && !cm_fault)
        else begin
            $error("Done or error output high after reset");
            failures++;
        end

endmodule

bind mem_subsystem mem_subsystem_asserts u_asserts (.*);

//--- testbench/mem_subsystem_tb.sv
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_subsystem_tb;

    localparam int TIMEOUT_CYCLES = 20;

    logic                  clk;
    logic                  reset;
    logic                  ld_valid;
    logic [`LSU_XLEN-1:0]  ld_addr;
    lsu_pkg::mem_op_t      ld_op;
    logic [`LSU_TAG_W-1:0] ld_tag;
    logic                  ld_done;
    logic [`LSU_XLEN-1:0]  ld_data;
    logic [`LSU_TAG_W-1:0] ld_tag_out;
    logic                  ld_fault;
    logic                  cm_valid;
    logic                  cm_is_store;
    logic [`LSU_XLEN-1:0]  cm_addr;
    lsu_pkg::mem_op_t      cm_op;
    logic [`LSU_XLEN-1:0]  cm_value;
    logic                  cm_done;
    logic                  cm_violation;
    logic                  cm_fault;

    logic [`LSU_XLEN-1:0]  model [0:`LSU_MEM_WORDS-1];  // Expected memory contents

    mem_subsystem UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(UUT.u_asserts.failures) begin
        if (UUT.u_asserts.failures != 0) begin
            $display("A bound timing assertion failed on the DUT ports");
            stop_with_failure();
        end
    end

    function automatic logic [`LSU_IDX_W-1:0] word_index(logic [31:0] addr);
        return addr[`LSU_IDX_W+1:2];  // Upper bits wrap
    endfunction

    function automatic logic misaligned_access(logic [1:0] off, lsu_pkg::mem_op_t op);
        case (op)
            lsu_pkg::OP_H, lsu_pkg::OP_HU: return off[0];
            lsu_pkg::OP_W:                 return off != 2'd0;
            default:                       return 1'b0;
        endcase
    endfunction

    // Lane select and extension by width and sign
    function automatic logic [31:0] expected_load(logic [31:0] word, logic [1:0] off,
                                                  lsu_pkg::mem_op_t op);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            lsu_pkg::OP_B:  return {{24{b[7]}}, b};
            lsu_pkg::OP_BU: return {24'h0, b};
            lsu_pkg::OP_H:  return {{16{h[15]}}, h};
            lsu_pkg::OP_HU: return {16'h0, h};
            lsu_pkg::OP_W:  return word;
            default:        return 32'h0;
        endcase
    endfunction

    function automatic void apply_store(logic [31:0] addr, lsu_pkg::mem_op_t op,
                                        logic [31:0] value);
        logic [`LSU_IDX_W-1:0] idx;
        logic [1:0]            off;
        idx = word_index(addr);
        off = addr[1:0];
        if (!misaligned_access(off, op)) begin  // Faulting store leaves memory alone
            case (op)
                lsu_pkg::OP_B: model[idx][8*off +: 8] = value[7:0];
                lsu_pkg::OP_H: model[idx][8*off +: 16] = value[15:0];
                lsu_pkg::OP_W: model[idx] = value;
                default: ;
            endcase
        end
    endfunction

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic wait_load_done();
        int cycles;
        cycles = 0;
        while (ld_done !== 1'b1) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Timeout: ld_done never went high after a load");
                stop_with_failure();
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    task automatic wait_commit_done();
        int cycles;
        cycles = 0;
        while (cm_done !== 1'b1) begin
            if (cycles == TIMEOUT_CYCLES) begin
                $display("Timeout: cm_done never went high after a commit");
                stop_with_failure();
            end else begin
                @(posedge clk);
                #2;
                cycles++;
            end
        end
    endtask

    // One speculative load checked against the model
    task automatic load_and_check(logic [31:0] addr, lsu_pkg::mem_op_t op);
        logic [5:0]  tag;
        logic [31:0] exp;
        logic        exp_fault;
        tag       = 6'($urandom);
        exp_fault = misaligned_access(addr[1:0], op);
        exp       = exp_fault ? 32'h0 : expected_load(model[word_index(addr)], addr[1:0], op);
        ld_valid  = 1'b1;
        ld_addr   = addr;
        ld_op     = op;
        ld_tag    = tag;
        @(posedge clk);
        #2;
        ld_valid = 1'b0;
        wait_load_done();
        check_value("ld_data", ld_data, exp);
        check_value("ld_tag_out", 32'(ld_tag_out), 32'(tag));
        check_value("ld_fault", 32'(ld_fault), 32'(exp_fault));
    endtask

    task automatic commit_and_check(logic is_store, logic [31:0] addr,
                                    lsu_pkg::mem_op_t op, logic [31:0] value,
                                    logic exp_violation);
        logic exp_fault;
        exp_fault   = misaligned_access(addr[1:0], op);
        cm_valid    = 1'b1;
        cm_is_store = is_store;
        cm_addr     = addr;
        cm_op       = op;
        cm_value    = value;
        @(posedge clk);
        #2;
        cm_valid = 1'b0;
        wait_commit_done();
        check_value("cm_violation", 32'(cm_violation), 32'(exp_violation));
        check_value("cm_fault", 32'(cm_fault), 32'(exp_fault));
        if (is_store)
            apply_store(addr, op, value);
    endtask

    task automatic verify_reset_contents();
        for (int n = 0; n < 12; n++)
            load_and_check($urandom & 32'hFFFF_FFFC, lsu_pkg::OP_W);  // Wide random addresses
    endtask

    task automatic subword_loads();
        logic [31:0] base;
        base = $urandom & 32'h3FFC;
        commit_and_check(1'b1, base, lsu_pkg::OP_W, 32'hF1B2_93D4, 1'b0);  // Every MSB set
        for (int off = 0; off < 4; off++) begin
            load_and_check(base + 32'(off), lsu_pkg::OP_B);
            load_and_check(base + 32'(off), lsu_pkg::OP_BU);
            if (off % 2 == 0) begin
                load_and_check(base + 32'(off), lsu_pkg::OP_H);
                load_and_check(base + 32'(off), lsu_pkg::OP_HU);
            end
        end
    endtask

    task automatic store_lane_merging();
        logic [31:0] base;
        base = $urandom & 32'h3FFC;
        for (int off = 0; off < 4; off++) begin
            commit_and_check(1'b1, base + 32'(off), lsu_pkg::OP_B, $urandom, 1'b0);
            load_and_check(base, lsu_pkg::OP_W);
        end
        commit_and_check(1'b1, base + 32'd2, lsu_pkg::OP_H, $urandom, 1'b0);
        load_and_check(base, lsu_pkg::OP_W);
        commit_and_check(1'b1, base, lsu_pkg::OP_H, $urandom, 1'b0);
        load_and_check(base, lsu_pkg::OP_W);
    endtask

    task automatic commit_verification();
        logic [31:0] addr;
        logic [31:0] good;
        addr = ($urandom & 32'h3FFC) | 32'd3;
        good = expected_load(model[word_index(addr)], 2'd3, lsu_pkg::OP_B);
        commit_and_check(1'b0, addr, lsu_pkg::OP_B, good, 1'b0);
        commit_and_check(1'b0, addr, lsu_pkg::OP_B, good ^ 32'h80, 1'b1);
        addr = ($urandom & 32'h3FFC) | 32'd2;
        good = expected_load(model[word_index(addr)], 2'd2, lsu_pkg::OP_HU);
        commit_and_check(1'b0, addr, lsu_pkg::OP_HU, good, 1'b0);
        commit_and_check(1'b0, addr, lsu_pkg::OP_HU, good + 32'd1, 1'b1);
        addr = $urandom & 32'h3FFC;
        good = model[word_index(addr)];
        commit_and_check(1'b0, addr, lsu_pkg::OP_W, good, 1'b0);
        commit_and_check(1'b0, addr, lsu_pkg::OP_W, ~good, 1'b1);
    endtask

    task automatic misaligned_accesses();
        logic [31:0] base;
        base = $urandom & 32'h3FFC;
        load_and_check(base + 32'd1, lsu_pkg::OP_H);
        load_and_check(base + 32'd3, lsu_pkg::OP_HU);
        load_and_check(base + 32'd2, lsu_pkg::OP_W);
        commit_and_check(1'b0, base + 32'd1, lsu_pkg::OP_H, 32'h0, 1'b0);
        commit_and_check(1'b0, base + 32'd3, lsu_pkg::OP_W, 32'h0, 1'b0);
        commit_and_check(1'b1, base + 32'd2, lsu_pkg::OP_W, 32'hDEAD_BEEF, 1'b0);
        commit_and_check(1'b1, base + 32'd1, lsu_pkg::OP_H, 32'h0000_CAFE, 1'b0);
        load_and_check(base, lsu_pkg::OP_W);  // Word must be untouched
    endtask

    // Back-to-back issue with one result per cycle in issue order
    task automatic pipelined_loads();
        lsu_pkg::mem_op_t ops [4];
        lsu_pkg::mem_op_t op;
        logic [31:0]      addr;
        logic [31:0]      exp;
        logic [5:0]       tag;
        ops = '{lsu_pkg::OP_W, lsu_pkg::OP_B, lsu_pkg::OP_HU, lsu_pkg::OP_BU};
        for (int i = 0; i < 8; i++) begin
            op   = ops[i % 4];
            addr = $urandom & 32'hFFFC;
            if (op == lsu_pkg::OP_HU)
                addr = addr + ($urandom & 32'd2);
            else if (op != lsu_pkg::OP_W)
                addr = addr + ($urandom & 32'd3);
            tag      = 6'(i * 5 + 3);
            exp      = expected_load(model[word_index(addr)], addr[1:0], op);
            ld_valid = 1'b1;
            ld_addr  = addr;
            ld_op    = op;
            ld_tag   = tag;
            @(posedge clk);
            #2;
            check_value("ld_done", 32'(ld_done), 32'h1);
            check_value("ld_tag_out", 32'(ld_tag_out), 32'(tag));
            check_value("ld_data", ld_data, exp);
        end
        ld_valid = 1'b0;
        @(posedge clk);
        #2;
        check_value("ld_done", 32'(ld_done), 32'h0);
    endtask

    initial begin
        void'($urandom(32'h8d71));
        for (int i = 0; i < `LSU_MEM_WORDS; i++)
            model[i] = 32'(i + 3);
        reset       = 1'b1;
        ld_valid    = 1'b0;
        ld_addr     = '0;
        ld_op       = lsu_pkg::OP_W;
        ld_tag      = '0;
        cm_valid    = 1'b0;
        cm_is_store = 1'b0;
        cm_addr     = '0;
        cm_op       = lsu_pkg::OP_W;
        cm_value    = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check_value("ld_done", 32'(ld_done), 32'h0);
        check_value("cm_done", 32'(cm_done), 32'h0);

        verify_reset_contents();
        subword_loads();
        store_lane_merging();
        commit_verification();
        misaligned_accesses();
        pipelined_loads();

        @(posedge clk);
        #2;
        $display("All checks passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/lsu_pkg.sv
logic/data_memory.sv
logic/load_extract.sv
logic/load_issue.sv
logic/commit_check.sv
logic/mem_subsystem.sv
testbench/mem_subsystem_asserts.sv
testbench/mem_subsystem_tb.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/data_memory.sv
      - logic/load_extract.sv
      - logic/load_issue.sv
      - logic/commit_check.sv
      - logic/mem_subsystem.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/mem_subsystem_asserts.sv
      - testbench/mem_subsystem_tb.sv
